//--- Bender.yml
package:
  name: macHostIf

sources:
  - common/macHostPkg.sv
  - hdl/hostBusCtrl.sv
  - macCfgRegs/macCfgRegs.sv
  - hdl/rmonCounters.sv
  - hdl/miimCmdRegs.sv
  - hdl/macHostIf.sv
  - target: simulation
    files:
      - sim/macHostIfChecker.sv
      - sim/macHostIfTb.sv

//--- common/macHostPkg.sv
package macHostPkg;

    // Word addresses on the host bus, cpuAddr[7:1]
    typedef enum logic [6:0] {
        addrTxHwmark    = 7'd0,
        addrTxLwmark    = 7'd1,
        addrPauseQuanta = 7'd3,
        addrIfgSet      = 7'd4,
        addrFullDuplex  = 7'd5,
        addrMaxRetry    = 7'd6,
        addrRxHwmark    = 7'd22,
        addrRxLwmark    = 7'd23,
        addrCrcChkEn    = 7'd24,
        addrRxIfgSet    = 7'd25,
        addrRxMaxLength = 7'd26,
        addrRxMinLength = 7'd27,
        addrRmonAddr    = 7'd28,
        addrRmonCmd     = 7'd29,
        addrRmonStatus  = 7'd30,
        addrRmonDataLo  = 7'd31,
        addrRmonDataHi  = 7'd32,
        addrLineLoopEn  = 7'd33,
        addrSpeed       = 7'd34,
        addrMiiDivider  = 7'd40,
        addrMiiCommand  = 7'd41,
        addrMiiAddress  = 7'd42,
        addrMiiCtrlData = 7'd43,
        addrMiiRxData   = 7'd44,
        addrMiiStatus   = 7'd45
    } regAddr;

    typedef enum logic [1:0] {
        idle,
        rmonReq,        // Apply held high until grant
        rmonCapture     // Counter word taken from rmonDout
    } hostState;

    // Field widths
    localparam int dataW     = 16;
    localparam int wmarkW    = 5;
    localparam int ifgW      = 6;
    localparam int retryW    = 4;
    localparam int minLenW   = 7;
    localparam int speedW    = 3;
    localparam int rmonIdxW  = 3;
    localparam int cntW      = 32;
    localparam int dividerW  = 8;
    localparam int phyAddrW  = 5;

    // Reset values of the configuration registers
    localparam logic [wmarkW-1:0]  txHwmarkRst    = 5'h1a;
    localparam logic [wmarkW-1:0]  txLwmarkRst    = 5'h09;
    localparam logic [dataW-1:0]   pauseQuantaRst = 16'h0000;
    localparam logic [ifgW-1:0]    ifgSetRst      = 6'h0c;
    localparam logic               fullDuplexRst  = 1'b1;
    localparam logic [retryW-1:0]  maxRetryRst    = 4'h2;
    localparam logic [wmarkW-1:0]  rxHwmarkRst    = 5'h1a;
    localparam logic [wmarkW-1:0]  rxLwmarkRst    = 5'h10;
    localparam logic               crcChkEnRst    = 1'b1;
    localparam logic [ifgW-1:0]    rxIfgSetRst    = 6'h0c;
    localparam logic [dataW-1:0]   rxMaxLengthRst = 16'h2710;   // 10000 bytes
    localparam logic [minLenW-1:0] rxMinLengthRst = 7'h40;      // 64 bytes
    localparam logic               lineLoopEnRst  = 1'b0;
    localparam logic [speedW-1:0]  speedRst       = 3'h4;       // Gigabit

endpackage

//--- compile.f
common/macHostPkg.sv
hdl/hostBusCtrl.sv
macCfgRegs/macCfgRegs.sv
hdl/rmonCounters.sv
hdl/miimCmdRegs.sv
hdl/macHostIf.sv
sim/macHostIfChecker.sv
sim/macHostIfTb.sv

//--- hdl/hostBusCtrl.sv
`timescale 1ns/1ps

module hostBusCtrl import macHostPkg::*; (
    input  logic                Clk_reg,
    input  logic                Clk,
    input  logic                csB,
    input  logic                wrB,
    input  logic [7:0]          cpuAddr,
    input  logic [dataW-1:0]    cpuDataIn,
    input  logic [dataW-1:0]    cfgRdData,
    input  logic [dataW-1:0]    miiRdData,
    input  logic                rmonGrant,
    input  logic [cntW-1:0]     rmonDout,
    output logic                wrStrobe,
    output regAddr              wrIdx,
    output logic [dataW-1:0]    wrData,
    output regAddr              rdIdx,
    output logic [dataW-1:0]    cpuDataOut,
    output logic                rdValid,
    output logic                rmonApply,
    output logic [rmonIdxW-1:0] rmonIdx
);

    hostState            state;
    logic [rmonIdxW-1:0] rmonAddrReg;
    logic [cntW-1:0]     rmonData;
    logic                rdAccess;
    logic                rmonStart;
    logic                busy;
    logic [dataW-1:0]    rdWord;

    // One bus cycle per access with csB low
    assign wrStrobe  = !csB && !wrB;
    assign rdAccess  = !csB && wrB;
    assign wrIdx     = regAddr'(cpuAddr[7:1]);
    assign rdIdx     = regAddr'(cpuAddr[7:1]);
    assign wrData    = cpuDataIn;

    assign rmonStart = wrStrobe && (wrIdx == addrRmonCmd) && wrData[0];
    assign busy      = (state != idle);
    assign rmonApply = (state == rmonReq);
    assign rmonIdx   = rmonAddrReg;

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            rmonAddrReg <= '0;
        end else if (wrStrobe && wrIdx == addrRmonAddr) begin
            rmonAddrReg <= wrData[rmonIdxW-1:0];
        end
    end

    // RMON fetch FSM
    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            state    <= idle;
            rmonData <= '0;
        end else begin
            case (state)
                idle:        if (rmonStart) state <= rmonReq;   // Dropped while busy
                rmonReq:     if (rmonGrant) state <= rmonCapture;
                rmonCapture: begin
                    rmonData <= rmonDout;   // Held by rmonCounters after the grant
                    state    <= idle;
                end
                default:     state <= idle;
            endcase
        end
    end

    // Other blocks answer 0 outside their own words
    always_comb begin
        rdWord = cfgRdData | miiRdData;
        case (rdIdx)
            addrRmonAddr:   rdWord = dataW'(rmonAddrReg);
            addrRmonStatus: rdWord = {{(dataW-1){1'b0}}, busy};
            addrRmonDataLo: rdWord = rmonData[dataW-1:0];
            addrRmonDataHi: rdWord = rmonData[cntW-1:dataW];
            default:        ;
        endcase
    end

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdAccess;
        end
    end

    always_ff @(posedge Clk_reg) begin
        if (rdAccess) cpuDataOut <= rdWord;
    end

    // Grant comes at most two cycles into a request
    assert property (@(posedge Clk_reg) disable iff (Clk)
        (rmonApply && $past(rmonApply) && $past(rmonApply, 2)) |-> rmonGrant);

    // Counter block only answers an open request
    assert property (@(posedge Clk_reg) disable iff (Clk)
        rmonGrant |-> rmonApply);

endmodule

//--- hdl/macHostIf.sv
`timescale 1ns/1ps

module macHostIf import macHostPkg::*; (
    input  logic                Clk_reg,
    input  logic                Clk,
    // CPU bus
    input  logic                csB,
    input  logic                wrB,
    input  logic [7:0]          cpuAddr,
    input  logic [dataW-1:0]    cpuDataIn,
    output logic [dataW-1:0]    cpuDataOut,
    output logic                rdValid,
    // Configuration
    output logic [wmarkW-1:0]   txHwmark,
    output logic [wmarkW-1:0]   txLwmark,
    output logic [dataW-1:0]    pauseQuantaSet,
    output logic [ifgW-1:0]     ifgSet,
    output logic                fullDuplex,
    output logic [retryW-1:0]   maxRetry,
    output logic [wmarkW-1:0]   rxHwmark,
    output logic [wmarkW-1:0]   rxLwmark,
    output logic                crcChkEn,
    output logic [ifgW-1:0]     rxIfgSet,
    output logic [dataW-1:0]    rxMaxLength,
    output logic [minLenW-1:0]  rxMinLength,
    output logic                lineLoopEn,
    output logic [speedW-1:0]   speed,
    // Statistics events from the MAC
    input  logic                statEvent,
    input  logic [rmonIdxW-1:0] statIdx,
    // MII management engine
    input  logic                busy,
    input  logic                linkFail,
    input  logic                nvalid,
    input  logic [dataW-1:0]    prsd,
    input  logic                wCtrlDataStart,
    input  logic                rStatStart,
    input  logic                updateMiiRxData,
    output logic [dividerW-1:0] divider,
    output logic [dataW-1:0]    ctrlData,
    output logic [phyAddrW-1:0] rgad,
    output logic [phyAddrW-1:0] fiad,
    output logic                noPre,
    output logic                wCtrlData,
    output logic                rStat,
    output logic                scanStat
);

    logic                wrStrobe;
    regAddr              wrIdx;
    regAddr              rdIdx;
    logic [dataW-1:0]    wrData;
    logic [dataW-1:0]    cfgRdData;
    logic [dataW-1:0]    miiRdData;
    logic                rmonApply;
    logic                rmonGrant;
    logic [rmonIdxW-1:0] rmonIdx;
    logic [cntW-1:0]     rmonDout;

    hostBusCtrl u_hostBusCtrl (
        .Clk_reg, .Clk, .csB, .wrB, .cpuAddr, .cpuDataIn,
        .cfgRdData, .miiRdData, .rmonGrant, .rmonDout,
        .wrStrobe, .wrIdx, .wrData, .rdIdx,
        .cpuDataOut, .rdValid, .rmonApply, .rmonIdx
    );

    macCfgRegs u_macCfgRegs (
        .Clk_reg, .Clk, .wrStrobe, .wrIdx, .wrData, .rdIdx, .cfgRdData,
        .txHwmark, .txLwmark, .pauseQuantaSet, .ifgSet, .fullDuplex, .maxRetry,
        .rxHwmark, .rxLwmark, .crcChkEn, .rxIfgSet, .rxMaxLength, .rxMinLength,
        .lineLoopEn, .speed
    );

    rmonCounters u_rmonCounters (
        .Clk_reg, .Clk, .statEvent, .statIdx,
        .rmonApply, .rmonIdx, .rmonGrant, .rmonDout
    );

    miimCmdRegs u_miimCmdRegs (
        .Clk_reg, .Clk, .wrStrobe, .wrIdx, .wrData, .rdIdx,
        .busy, .linkFail, .nvalid, .prsd,
        .wCtrlDataStart, .rStatStart, .updateMiiRxData,
        .miiRdData, .divider, .ctrlData, .rgad, .fiad, .noPre,
        .wCtrlData, .rStat, .scanStat
    );

endmodule

//--- hdl/miimCmdRegs.sv
`timescale 1ns/1ps

module miimCmdRegs import macHostPkg::*; (
    input  logic                Clk_reg,
    input  logic                Clk,
    input  logic                wrStrobe,
    input  regAddr              wrIdx,
    input  logic [dataW-1:0]    wrData,
    input  regAddr              rdIdx,
    input  logic                busy,
    input  logic                linkFail,
    input  logic                nvalid,
    input  logic [dataW-1:0]    prsd,
    input  logic                wCtrlDataStart,
    input  logic                rStatStart,
    input  logic                updateMiiRxData,
    output logic [dataW-1:0]    miiRdData,
    output logic [dividerW-1:0] divider,
    output logic [dataW-1:0]    ctrlData,
    output logic [phyAddrW-1:0] rgad,
    output logic [phyAddrW-1:0] fiad,
    output logic                noPre,
    output logic                wCtrlData,
    output logic                rStat,
    output logic                scanStat
);

    logic [dataW-1:0] miiRxData;
    logic             cmdWr;

    assign cmdWr = wrStrobe && (wrIdx == addrMiiCommand);

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            divider  <= '0;
            ctrlData <= '0;
            rgad     <= '0;
            fiad     <= '0;
            noPre    <= 1'b0;
        end else if (wrStrobe) begin
            case (wrIdx)
                addrMiiDivider:  divider  <= wrData[dividerW-1:0];
                addrMiiCtrlData: ctrlData <= wrData;
                addrMiiAddress: begin
                    fiad  <= wrData[phyAddrW-1:0];
                    rgad  <= wrData[8 +: phyAddrW];
                    noPre <= wrData[15];
                end
                default: ;
            endcase
        end
    end

    // Start pulses from the serial engine clear the request, ahead of a write
    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            wCtrlData <= 1'b0;
            rStat     <= 1'b0;
            scanStat  <= 1'b0;
        end else begin
            if (wCtrlDataStart) wCtrlData <= 1'b0;
            else if (cmdWr)     wCtrlData <= wrData[2];
            if (rStatStart)     rStat     <= 1'b0;
            else if (cmdWr)     rStat     <= wrData[1];
            if (cmdWr)          scanStat  <= wrData[0];
        end
    end

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            miiRxData <= '0;
        end else if (updateMiiRxData) begin
            miiRxData <= prsd;   // Host writes never land here
        end
    end

    always_comb begin
        case (rdIdx)
            addrMiiDivider:  miiRdData = dataW'(divider);
            addrMiiCommand:  miiRdData = dataW'({wCtrlData, rStat, scanStat});
            addrMiiAddress:  miiRdData = {noPre, 2'b00, rgad, 3'b000, fiad};
            addrMiiCtrlData: miiRdData = ctrlData;
            addrMiiRxData:   miiRdData = miiRxData;
            addrMiiStatus:   miiRdData = dataW'({nvalid, linkFail, busy});
            default:         miiRdData = '0;
        endcase
    end

    // Write request is gone the cycle after the engine picks it up
    assert property (@(posedge Clk_reg) disable iff (Clk)
        wCtrlDataStart |=> !wCtrlData);

endmodule

//--- hdl/rmonCounters.sv
`timescale 1ns/1ps

module rmonCounters import macHostPkg::*; (
    input  logic                Clk_reg,
    input  logic                Clk,
    input  logic                statEvent,
    input  logic [rmonIdxW-1:0] statIdx,
    input  logic                rmonApply,
    input  logic [rmonIdxW-1:0] rmonIdx,
    output logic                rmonGrant,
    output logic [cntW-1:0]     rmonDout
);

    logic [cntW-1:0] counters [1 << rmonIdxW];
    logic            deferred;
    logic            grantNow;
    logic            hit;

    // Grant goes out a cycle late if an event collides with the first apply
    assign grantNow = rmonApply && !rmonGrant && (deferred || !statEvent);
    assign hit      = statEvent && (statIdx == rmonIdx);

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            for (int i = 0; i < (1 << rmonIdxW); i++) begin
                counters[i] <= '0;
            end
        end else if (statEvent) begin
            counters[statIdx] <= counters[statIdx] + 1'b1;   // Wraps at 32 bits
        end
    end

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            rmonGrant <= 1'b0;
            deferred  <= 1'b0;
        end else begin
            rmonGrant <= grantNow;
            deferred  <= rmonApply && !rmonGrant && !deferred && statEvent;
        end
    end

    // Snapshot includes an event landing on the same edge
    always_ff @(posedge Clk_reg) begin
        if (grantNow) rmonDout <= counters[rmonIdx] + cntW'(hit);
    end

endmodule

//--- macCfgRegs/macCfgRegs.sv
`timescale 1ns/1ps

module macCfgRegs import macHostPkg::*; (
    input  logic               Clk_reg,
    input  logic               Clk,
    input  logic               wrStrobe,
    input  regAddr             wrIdx,
    input  logic [dataW-1:0]   wrData,
    input  regAddr             rdIdx,
    output logic [dataW-1:0]   cfgRdData,
    // Transmit side
    output logic [wmarkW-1:0]  txHwmark,
    output logic [wmarkW-1:0]  txLwmark,
    output logic [dataW-1:0]   pauseQuantaSet,
    output logic [ifgW-1:0]    ifgSet,
    output logic               fullDuplex,
    output logic [retryW-1:0]  maxRetry,
    // Receive side
    output logic [wmarkW-1:0]  rxHwmark,
    output logic [wmarkW-1:0]  rxLwmark,
    output logic               crcChkEn,
    output logic [ifgW-1:0]    rxIfgSet,
    output logic [dataW-1:0]   rxMaxLength,
    output logic [minLenW-1:0] rxMinLength,
    // PHY side
    output logic               lineLoopEn,
    output logic [speedW-1:0]  speed
);

    always_ff @(posedge Clk_reg or posedge Clk) begin
        if (Clk) begin
            txHwmark       <= txHwmarkRst;
            txLwmark       <= txLwmarkRst;
            pauseQuantaSet <= pauseQuantaRst;
            ifgSet         <= ifgSetRst;
            fullDuplex     <= fullDuplexRst;
            maxRetry       <= maxRetryRst;
            rxHwmark       <= rxHwmarkRst;
            rxLwmark       <= rxLwmarkRst;
            crcChkEn       <= crcChkEnRst;
            rxIfgSet       <= rxIfgSetRst;
            rxMaxLength    <= rxMaxLengthRst;
            rxMinLength    <= rxMinLengthRst;
            lineLoopEn     <= lineLoopEnRst;
            speed          <= speedRst;
        end else if (wrStrobe) begin
            // Upper bits of the bus word are dropped
            case (wrIdx)
                addrTxHwmark:    txHwmark       <= wrData[wmarkW-1:0];
                addrTxLwmark:    txLwmark       <= wrData[wmarkW-1:0];
                addrPauseQuanta: pauseQuantaSet <= wrData;
                addrIfgSet:      ifgSet         <= wrData[ifgW-1:0];
                addrFullDuplex:  fullDuplex     <= wrData[0];
                addrMaxRetry:    maxRetry       <= wrData[retryW-1:0];
                addrRxHwmark:    rxHwmark       <= wrData[wmarkW-1:0];
                addrRxLwmark:    rxLwmark       <= wrData[wmarkW-1:0];
                addrCrcChkEn:    crcChkEn       <= wrData[0];
                addrRxIfgSet:    rxIfgSet       <= wrData[ifgW-1:0];
                addrRxMaxLength: rxMaxLength    <= wrData;
                addrRxMinLength: rxMinLength    <= wrData[minLenW-1:0];
                addrLineLoopEn:  lineLoopEn     <= wrData[0];
                addrSpeed:       speed          <= wrData[speedW-1:0];
                default:         ;             // Not a configuration word
            endcase
        end
    end

    always_comb begin
        cfgRdData = '0;
        case (rdIdx)
            addrTxHwmark:    cfgRdData = dataW'(txHwmark);
            addrTxLwmark:    cfgRdData = dataW'(txLwmark);
            addrPauseQuanta: cfgRdData = pauseQuantaSet;
            addrIfgSet:      cfgRdData = dataW'(ifgSet);
            addrFullDuplex:  cfgRdData = dataW'(fullDuplex);
            addrMaxRetry:    cfgRdData = dataW'(maxRetry);
            addrRxHwmark:    cfgRdData = dataW'(rxHwmark);
            addrRxLwmark:    cfgRdData = dataW'(rxLwmark);
            addrCrcChkEn:    cfgRdData = dataW'(crcChkEn);
            addrRxIfgSet:    cfgRdData = dataW'(rxIfgSet);
            addrRxMaxLength: cfgRdData = rxMaxLength;
            addrRxMinLength: cfgRdData = dataW'(rxMinLength);
            addrLineLoopEn:  cfgRdData = dataW'(lineLoopEn);
            addrSpeed:       cfgRdData = dataW'(speed);
            default:         cfgRdData = '0;
        endcase
    end

endmodule

//--- sim/macHostIfChecker.sv
`timescale 1ns/1ps

module macHostIfChecker (
    input  logic        Clk_reg,
    input  logic        Clk,
    input  logic        csB,
    input  logic        wrB,
    input  logic        rdValid,
    input  logic [15:0] cpuDataOut
);

    string       testName = "none";
    int          readCount = 0;
    int          readErrs = 0;
    int          portErrs = 0;
    int          protoErrs = 0;
    logic [31:0] pending [$];   // {mask, expected} per read in flight
    logic [31:0] entry;
    logic        readLast = 1'b0;   // Read access taken on the previous edge

    task automatic startTest(input string name);
        testName = name;
    endtask

    task automatic expectRead(input logic [15:0] exp, input logic [15:0] mask);
        pending.push_back({mask, exp});
    endtask

    task automatic comparePort(input string port, input logic [15:0] exp,
                               input logic [15:0] act);
        if (exp !== act) begin
            portErrs++;
            $display("** Error %s port %s: expected %h actual %h", testName, port, exp, act);
        end
    endtask

    // Read word is valid for the whole cycle after the access
    always @(posedge Clk_reg) begin
        if (!Clk && rdValid !== readLast) begin
            protoErrs++;
            $display("** Error %s rdValid: expected %b actual %b", testName,
                     readLast, rdValid);
        end
        if (!Clk && rdValid) begin
            if (pending.size() == 0) begin
                protoErrs++;
                $display("rdValid pulsed in %s with no read pending", testName);
            end else begin
                entry = pending.pop_front();
                readCount++;
                if ((cpuDataOut & entry[31:16]) !== (entry[15:0] & entry[31:16])) begin
                    readErrs++;
                    $display("** Error %s: expected %h actual %h", testName,
                             entry[15:0] & entry[31:16], cpuDataOut & entry[31:16]);
                end
            end
        end
        readLast = !Clk && !csB && wrB;
    end

    task automatic finalCheck();
        if (pending.size() != 0) begin
            protoErrs++;
            $display("%0d reads never got rdValid", pending.size());
        end
    endtask

endmodule

//--- sim/macHostIfTb.sv
`timescale 1ns/1ps

module macHostIfTb;

    localparam int randOps  = 120;
    localparam int fetches  = 8;
    localparam int miiRounds = 8;
    localparam int numOps   = 14 + 2 * randOps + 256 + 30 * fetches + 20 * miiRounds;

    logic        Clk_reg;
    logic        Clk;
    logic        csB, wrB, rdValid;
    logic [7:0]  cpuAddr, divider;
    logic [15:0] cpuDataIn, cpuDataOut, pauseQuantaSet, rxMaxLength, prsd, ctrlData;
    logic [4:0]  txHwmark, txLwmark, rxHwmark, rxLwmark, rgad, fiad;
    logic [5:0]  ifgSet, rxIfgSet;
    logic [3:0]  maxRetry;
    logic [6:0]  rxMinLength;
    logic [2:0]  speed, statIdx;
    logic        fullDuplex, crcChkEn, lineLoopEn, noPre, wCtrlData, rStat, scanStat;
    logic        statEvent, busy, linkFail, nvalid;
    logic        wCtrlDataStart, rStatStart, updateMiiRxData;

    logic [31:0] lfsr;
    logic [15:0] regModel [128];
    logic [31:0] cntModel [8];
    logic [31:0] rmonModel;
    logic [15:0] rxDataModel;
    logic [15:0] rd;
    logic [2:0]  fetchIdx;
    logic [6:0]  a;
    int          evMode;   // 0 quiet, 1 any counter, 2 all but fetchIdx

    macHostIf u_macHostIf (.*);

    macHostIfChecker chk (.Clk_reg, .Clk, .csB, .wrB, .rdValid, .cpuDataOut);

    always #5 Clk_reg = ~Clk_reg;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Bits a host write can set
    function automatic logic [15:0] writeMask(input logic [6:0] addr);
        case (addr)
            0, 1, 22, 23: return 16'h001f;
            3, 26, 43:    return 16'hffff;
            4, 25:        return 16'h003f;
            5, 24, 33:    return 16'h0001;
            6:            return 16'h000f;
            27:           return 16'h007f;
            28, 34, 41:   return 16'h0007;
            40:           return 16'h00ff;
            42:           return 16'h9f1f;
            default:      return 16'h0000;
        endcase
    endfunction

    function automatic bit isCfg(input logic [6:0] addr);
        return addr <= 34 && addr != 28 && writeMask(addr) != 0;
    endfunction

    function automatic logic [15:0] readModel(input logic [6:0] addr);
        case (addr)
            31:      return rmonModel[15:0];
            32:      return rmonModel[31:16];
            44:      return rxDataModel;
            45:      return {13'd0, nvalid, linkFail, busy};
            default: return regModel[addr];
        endcase
    endfunction

    task automatic resetModel();
        for (int i = 0; i < 128; i++) regModel[i] = '0;
        for (int i = 0; i < 8; i++) cntModel[i] = '0;
        regModel[0]  = 16'h001a;
        regModel[1]  = 16'h0009;
        regModel[4]  = 16'h000c;
        regModel[5]  = 16'h0001;
        regModel[6]  = 16'h0002;
        regModel[22] = 16'h001a;
        regModel[23] = 16'h0010;
        regModel[24] = 16'h0001;
        regModel[25] = 16'h000c;
        regModel[26] = 16'h2710;
        regModel[27] = 16'h0040;
        regModel[34] = 16'h0004;
        rmonModel    = '0;
        rxDataModel  = '0;
    endtask

    // Idle bus and a fresh statistics event for the coming edge
    task automatic nextCycle();
        @(negedge Clk_reg);
        csB             = 1'b1;
        wrB             = 1'b1;
        wCtrlDataStart  = 1'b0;
        rStatStart      = 1'b0;
        updateMiiRxData = 1'b0;
        statEvent       = 1'b0;
        if (evMode != 0) begin
            statEvent = randBits(1);
            if (evMode == 1) statIdx = randBits(3);
            else statIdx = (fetchIdx + 1 + randBits(3) % 7) % 8;
            if (statEvent) cntModel[statIdx] = cntModel[statIdx] + 1;
        end
    endtask

    task automatic writeReg(input logic [6:0] addr, input logic [15:0] data);
        csB       = 1'b0;
        wrB       = 1'b0;
        cpuAddr   = {addr, 1'b0} | randBits(1);   // Bit 0 is not decoded
        cpuDataIn = data;
        regModel[addr] = data & writeMask(addr);
        nextCycle();
    endtask

    task automatic readReg(input logic [6:0] addr, input logic [15:0] mask,
                           output logic [15:0] data);
        csB     = 1'b0;
        wrB     = 1'b1;
        cpuAddr = {addr, 1'b0} | randBits(1);
        chk.expectRead(readModel(addr), mask);
        nextCycle();
        data = cpuDataOut;
    endtask

    task automatic checkCfgPorts();
        chk.comparePort("txHwmark", regModel[0], txHwmark);
        chk.comparePort("txLwmark", regModel[1], txLwmark);
        chk.comparePort("pauseQuantaSet", regModel[3], pauseQuantaSet);
        chk.comparePort("ifgSet", regModel[4], ifgSet);
        chk.comparePort("fullDuplex", regModel[5], fullDuplex);
        chk.comparePort("maxRetry", regModel[6], maxRetry);
        chk.comparePort("rxHwmark", regModel[22], rxHwmark);
        chk.comparePort("rxLwmark", regModel[23], rxLwmark);
        chk.comparePort("crcChkEn", regModel[24], crcChkEn);
        chk.comparePort("rxIfgSet", regModel[25], rxIfgSet);
        chk.comparePort("rxMaxLength", regModel[26], rxMaxLength);
        chk.comparePort("rxMinLength", regModel[27], rxMinLength);
        chk.comparePort("lineLoopEn", regModel[33], lineLoopEn);
        chk.comparePort("speed", regModel[34], speed);
    endtask

    task automatic checkMiiPorts();
        chk.comparePort("divider", regModel[40], divider);
        chk.comparePort("fiad", regModel[42][4:0], fiad);
        chk.comparePort("rgad", regModel[42][12:8], rgad);
        chk.comparePort("noPre", regModel[42][15], noPre);
        chk.comparePort("ctrlData", regModel[43], ctrlData);
        chk.comparePort("wCtrlData", regModel[41][2], wCtrlData);
        chk.comparePort("rStat", regModel[41][1], rStat);
        chk.comparePort("scanStat", regModel[41][0], scanStat);
    endtask

    initial begin
        Clk_reg = 1'b0;
        Clk     = 1'b1;
        {csB, wrB} = 2'b11;
        cpuAddr   = '0;
        cpuDataIn = '0;
        {statEvent, statIdx, busy, linkFail, nvalid, prsd} = '0;
        {wCtrlDataStart, rStatStart, updateMiiRxData} = '0;
        lfsr   = 32'd66248;
        evMode = 0;
        resetModel();
        repeat (4) @(negedge Clk_reg);
        Clk = 1'b0;

        chk.startTest("resetValues");
        for (int i = 0; i <= 34; i++) if (isCfg(i)) readReg(i, 16'hffff, rd);
        checkCfgPorts();

        chk.startTest("randomCfg");
        for (int n = 0; n < randOps; n++) begin
            a = 7'd2;
            while (!isCfg(a)) a = randBits(6) % 35;
            writeReg(a, randBits(16));
            readReg(a, 16'hffff, rd);
        end
        checkCfgPorts();

        // Unowned words plus the read-only RMON and MIIM ones
        chk.startTest("unmapped");
        for (int i = 0; i < 128; i++) begin
            if (writeMask(i) == 0 && i != 29) begin
                writeReg(i, randBits(16));
                readReg(i, 16'hffff, rd);
            end
        end

        chk.startTest("rmonFetch");
        for (int n = 0; n < fetches; n++) begin
            evMode = 1;
            repeat (10) nextCycle();
            fetchIdx = randBits(3);
            evMode   = 2;
            writeReg(7'd28, (randBits(16) & 16'hfff8) | fetchIdx);
            readReg(7'd28, 16'hffff, rd);
            writeReg(7'd29, randBits(16) | 16'h0001);
            writeReg(7'd29, 16'h0001);   // Start while busy
            rd = 16'h0001;
            while (rd[0]) readReg(7'd30, 16'hfffe, rd);
            rmonModel = cntModel[fetchIdx];
            readReg(7'd31, 16'hffff, rd);
            readReg(7'd32, 16'hffff, rd);
        end
        evMode = 0;

        chk.startTest("miim");
        for (int n = 0; n < miiRounds; n++) begin
            writeReg(7'd40, randBits(16));
            writeReg(7'd42, randBits(16));
            writeReg(7'd43, randBits(16));
            writeReg(7'd41, randBits(16));
            readReg(7'd41, 16'hffff, rd);
            readReg(7'd42, 16'hffff, rd);
            readReg(7'd40, 16'hffff, rd);
            readReg(7'd43, 16'hffff, rd);
            checkMiiPorts();
            wCtrlDataStart = 1'b1;
            regModel[41][2] = 1'b0;
            nextCycle();
            readReg(7'd41, 16'hffff, rd);
            rStatStart = 1'b1;
            regModel[41][1] = 1'b0;
            nextCycle();
            checkMiiPorts();
            wCtrlDataStart = 1'b1;   // Clear beats the write
            writeReg(7'd41, 16'h0007);
            regModel[41][2] = 1'b0;
            readReg(7'd41, 16'hffff, rd);
            prsd            = randBits(16);
            updateMiiRxData = 1'b1;
            rxDataModel     = prsd;
            nextCycle();
            readReg(7'd44, 16'hffff, rd);
            {busy, linkFail, nvalid} = randBits(3);
            readReg(7'd45, 16'hffff, rd);
        end

        repeat (3) nextCycle();
        chk.finalCheck();
        $display("Reads %0d, read errors %0d, port errors %0d, protocol errors %0d",
                 chk.readCount, chk.readErrs, chk.portErrs, chk.protoErrs);
        if (chk.readErrs + chk.portErrs + chk.protoErrs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Hang guard sized from the operation count
    initial begin
        repeat (numOps * 20) @(posedge Clk_reg);
        $display("Watchdog fired in %s, the run hung after %0d cycles", chk.testName,
                 numOps * 20);
        $display("Reads %0d, read errors %0d, port errors %0d, protocol errors %0d",
                 chk.readCount, chk.readErrs, chk.portErrs, chk.protoErrs);
        $display(">>> FAIL");
        $finish;
    end

endmodule
